/* common/qspi_cfg.svh */
`ifndef QSPI_CFG_SVH
`define QSPI_CFG_SVH

// Flash byte address width, three address bytes on the wire
`define QSPI_ADDR_W 24

// Byte count of one read request
`define QSPI_LEN_W 16

// SCK divider width, LSB is not used
`define QSPI_DIV_W 16

// Quad output fast read opcode
`define QSPI_CMD_QREAD 8'h6B

`endif

/* common/qspi_pkg.sv */
`include "qspi_cfg.svh"

package qspi_pkg;

	// Start address of a read in flash byte space
	typedef logic [`QSPI_ADDR_W-1:0] flash_addr_t;

	// Number of bytes in one request, never zero
	typedef logic [`QSPI_LEN_W-1:0] xfer_len_t;

	// Zero based SCK divider
	// Half period is clkdiv[15:1]+1 clk cycles
	typedef logic [`QSPI_DIV_W-1:0] clk_div_t;

	// One byte as shifted over the pins
	typedef logic [7:0] qspi_byte_t;

	// Read sequencer phases
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_COMMAND,
		ST_ADDRESS,
		ST_DUMMY,
		ST_READ,
		ST_FINISH
	} seq_state_t;

endpackage

/* common/qspi_shift_if.sv */
`include "qspi_cfg.svh"

interface qspi_shift_if;
	import qspi_pkg::*;

	// Start pulses, one per byte
	logic shift_en;
	logic quad_shift_en;

	// Sampled in the shift_done cycle to chain the next byte
	logic auto_restart;

	// Byte to send in single bit mode
	qspi_byte_t tx_data;

	// End of byte pulse and the byte received with it
	logic shift_done;
	qspi_byte_t rx_data;

	modport seq (
		output shift_en, quad_shift_en, auto_restart, tx_data,
		input shift_done, rx_data
	);

	modport xcvr (
		input shift_en, quad_shift_en, auto_restart, tx_data,
		output shift_done, rx_data
	);

endinterface

/* design/qspi_flash_reader.sv */
module qspi_flash_reader (
	input logic clk,
	input logic reset,
	input qspi_pkg::clk_div_t clkdiv,
	input logic req_valid,
	output logic req_ready,
	input qspi_pkg::flash_addr_t req_addr,
	input qspi_pkg::xfer_len_t req_len,
	output logic rd_valid,
	input logic rd_ready,
	output qspi_pkg::qspi_byte_t rd_data,
	output logic rd_last,
	output logic qspi_sck,
	output logic qspi_cs_n,
	output logic [3:0] qspi_dq_out,
	output logic [3:0] qspi_dq_tris,
	input logic [3:0] qspi_dq_in
);

	// Byte shift control between sequencer and transceiver
	qspi_shift_if shift_bus ();

	// Request handling, header bytes and read stream
	qspi_read_sequencer u_seq (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_addr(req_addr),
		.req_len(req_len),
		.rd_valid(rd_valid),
		.rd_ready(rd_ready),
		.rd_data(rd_data),
		.rd_last(rd_last),
		.qspi_cs_n(qspi_cs_n),
		.shift(shift_bus.seq)
	);

	// SCK generation and pin level shifting
	qspi_host_transceiver u_xcvr (
		.clk(clk),
		.reset(reset),
		.clkdiv(clkdiv),
		.qspi_sck(qspi_sck),
		.qspi_dq_out(qspi_dq_out),
		.qspi_dq_in(qspi_dq_in),
		.qspi_dq_tris(qspi_dq_tris),
		.shift(shift_bus.xcvr)
	);

endmodule

/* qspi_flash_reader.f */
+incdir+common
common/qspi_pkg.sv
common/qspi_shift_if.sv
qspi_host/qspi_host_transceiver.sv
qspi_host/qspi_read_sequencer.sv
design/qspi_flash_reader.sv
testbench/qspi_flash_model.sv
testbench/tb_qspi_flash_reader.sv

/* qspi_host/qspi_host_transceiver.sv */
`include "qspi_cfg.svh"

module qspi_host_transceiver (
	input logic clk,
	input logic reset,
	input qspi_pkg::clk_div_t clkdiv,
	output logic qspi_sck,
	output logic [3:0] qspi_dq_out,
	input logic [3:0] qspi_dq_in,
	output logic [3:0] qspi_dq_tris,
	qspi_shift_if.xcvr shift
);
	import qspi_pkg::*;

	// Half period counter
	logic [`QSPI_DIV_W-2:0] half_cnt;
	logic half_done;

	// Shift state
	logic active;
	logic quad_active;
	logic done_q;
	logic [3:0] bit_cnt;

	// Remaining transmit bits and receive shifter
	logic [6:0] tx_shreg;
	qspi_byte_t rx_shreg;

	// Per cycle events
	logic start;
	logic restart;
	logic stop;
	logic load;
	logic next_quad;
	logic run;
	logic rise;
	logic fall;
	logic byte_end;

	assign half_done = (half_cnt >= clkdiv[`QSPI_DIV_W-1:1]);

	// A start pulse wins over everything else
	assign start = shift.shift_en || shift.quad_shift_en;

	// Decision taken in the cycle after the last falling edge
	assign restart = done_q && shift.auto_restart && !start;
	assign stop = done_q && !shift.auto_restart && !start;

	// Chained bytes keep the mode of the previous one
	assign load = start || restart;
	assign next_quad = start ? shift.quad_shift_en : quad_active;

	// SCK edges of a running byte
	assign run = active && !done_q && !start;
	assign rise = run && half_done && !qspi_sck;
	assign fall = run && half_done && qspi_sck;
	assign byte_end = fall && (bit_cnt == 4'd8);

	assign shift.shift_done = done_q;
	assign shift.rx_data = rx_shreg;

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			quad_active <= 1'b0;
			done_q <= 1'b0;
			half_cnt <= '0;
			bit_cnt <= '0;
			qspi_sck <= 1'b0;
			qspi_dq_out <= 4'b0000;
			qspi_dq_tris <= 4'b1110;
		end else begin
			done_q <= byte_end;
			if (load) begin
				active <= 1'b1;
				quad_active <= next_quad;
				bit_cnt <= '0;
				qspi_sck <= 1'b0;
				// Keep counting the low phase when chaining straight from a finished byte
				half_cnt <= done_q ? half_cnt + 1'b1 : '0;
				// Quad bytes are receive only
				qspi_dq_tris <= next_quad ? 4'b1111 : 4'b1110;
				qspi_dq_out <= {3'b000, !next_quad && shift.tx_data[7]};
			end else if (stop) begin
				// SCK is already low after the last falling edge
				active <= 1'b0;
				quad_active <= 1'b0;
			end else if (run) begin
				if (half_done) begin
					half_cnt <= '0;
					qspi_sck <= !qspi_sck;
					if (!qspi_sck) begin
						bit_cnt <= bit_cnt + (quad_active ? 4'd4 : 4'd1);
					end else if (byte_end) begin
						// Release the bus so the flash may drive after the dummy clocks
						bit_cnt <= '0;
						qspi_dq_tris <= 4'b1111;
						qspi_dq_out <= 4'b0000;
					end else begin
						qspi_dq_out[0] <= tx_shreg[6];
					end
				end else begin
					half_cnt <= half_cnt + 1'b1;
				end
			end
		end
	end

	// Data shifters
	always_ff @(posedge clk) begin
		if (load) begin
			tx_shreg <= next_quad ? 7'h00 : shift.tx_data[6:0];
		end else if (fall) begin
			tx_shreg <= {tx_shreg[5:0], 1'b0};
		end
		// Sample on the rising edge, MSB first
		if (rise) begin
			if (quad_active) begin
				rx_shreg <= {rx_shreg[3:0], qspi_dq_in};
			end else begin
				rx_shreg <= {rx_shreg[6:0], qspi_dq_in[1]};
			end
		end
	end

endmodule

/* qspi_host/qspi_read_sequencer.sv */
`include "qspi_cfg.svh"

module qspi_read_sequencer (
	input logic clk,
	input logic reset,
	input logic req_valid,
	output logic req_ready,
	input qspi_pkg::flash_addr_t req_addr,
	input qspi_pkg::xfer_len_t req_len,
	output logic rd_valid,
	input logic rd_ready,
	output qspi_pkg::qspi_byte_t rd_data,
	output logic rd_last,
	output logic qspi_cs_n,
	qspi_shift_if.seq shift
);
	import qspi_pkg::*;

	seq_state_t state;

	// Latched request
	flash_addr_t addr_q;

	// Bytes whose shift has not completed yet
	xfer_len_t remain;

	// Address byte in flight, 0 is the top byte
	logic [1:0] addr_cnt;

	// First byte start pulse
	logic kick;

	// A finished byte is parked in the transceiver receive register
	logic rx_pend;

	logic req_fire;
	logic out_free;
	logic rd_done;
	logic take_now;
	logic take_pend;
	logic last_fire;

	assign req_ready = (state == ST_IDLE);
	assign req_fire = req_valid && req_ready;

	// Output register can take a byte this cycle
	assign out_free = !rd_valid || rd_ready;

	assign rd_done = (state == ST_READ) && shift.shift_done;
	assign take_now = rd_done && out_free;
	assign take_pend = rx_pend && out_free;
	assign last_fire = rd_valid && rd_ready && rd_last;

	assign shift.shift_en = kick;

	// Enter quad mode right at the end of the dummy byte
	// or resume once a parked byte has moved to the output
	assign shift.quad_shift_en = ((state == ST_DUMMY) && shift.shift_done) ||
		(take_pend && (remain != '0));

	// Chain bytes through the header, and in the read phase only while the output can take data
	always_comb begin
		case (state)
			ST_COMMAND, ST_ADDRESS: shift.auto_restart = 1'b1;
			ST_READ: shift.auto_restart = take_now && (remain != xfer_len_t'(1));
			default: shift.auto_restart = 1'b0;
		endcase
	end

	// Header byte for the next shift
	always_comb begin
		shift.tx_data = '0;
		case (state)
			ST_COMMAND: begin
				if (shift.shift_done) begin
					shift.tx_data = addr_q[23:16];
				end else begin
					shift.tx_data = qspi_byte_t'(`QSPI_CMD_QREAD);
				end
			end
			ST_ADDRESS: begin
				// After the last address byte comes the all zero dummy byte
				case (addr_cnt)
					2'd0: shift.tx_data = addr_q[15:8];
					2'd1: shift.tx_data = addr_q[7:0];
					default: shift.tx_data = '0;
				endcase
			end
			default: shift.tx_data = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			kick <= 1'b0;
			qspi_cs_n <= 1'b1;
			addr_cnt <= '0;
			remain <= '0;
			rx_pend <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			kick <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (req_fire) begin
						state <= ST_COMMAND;
						kick <= 1'b1;
						qspi_cs_n <= 1'b0;
						remain <= req_len;
					end
				end
				ST_COMMAND: begin
					if (shift.shift_done) begin
						state <= ST_ADDRESS;
						addr_cnt <= '0;
					end
				end
				ST_ADDRESS: begin
					if (shift.shift_done) begin
						if (addr_cnt == 2'd2) begin
							state <= ST_DUMMY;
						end else begin
							addr_cnt <= addr_cnt + 1'b1;
						end
					end
				end
				ST_DUMMY: begin
					if (shift.shift_done) begin
						state <= ST_READ;
					end
				end
				ST_READ: begin
					// Deselect once the final byte leaves the output
					if (last_fire) begin
						state <= ST_FINISH;
						qspi_cs_n <= 1'b1;
					end
				end
				ST_FINISH: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase

			if (rd_done) begin
				remain <= remain - 1'b1;
			end

			// Park the byte in the transceiver while the output is blocked
			if (rd_done && !out_free) begin
				rx_pend <= 1'b1;
			end else if (take_pend) begin
				rx_pend <= 1'b0;
			end

			if (take_now || take_pend) begin
				rd_valid <= 1'b1;
			end else if (rd_ready) begin
				rd_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req_fire) begin
			addr_q <= req_addr;
		end
		if (take_now || take_pend) begin
			rd_data <= shift.rx_data;
			// A parked byte has already been counted
			rd_last <= take_now ? (remain == xfer_len_t'(1)) : (remain == '0);
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_qspi_flash_reader \
	-f qspi_flash_reader.f -o sim_tb || exit 1
./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0

/* testbench/qspi_flash_model.sv */
module qspi_flash_model (
	input logic qspi_sck,
	input logic qspi_cs_n,
	input logic [3:0] qspi_dq_out,
	input logic [3:0] qspi_dq_tris,
	output logic [3:0] qspi_dq_in,
	output logic [7:0] last_cmd,
	output logic [23:0] last_addr,
	output int header_count,
	output int protocol_errors
);

	// Header bits seen so far, 8 command then 24 address then 8 dummy
	int bit_cnt;
	logic [31:0] hdr_shreg;

	// Data phase
	logic driving = 1'b0;
	logic low_nibble;
	logic [23:0] rd_addr;
	logic [7:0] cur_byte;
	logic [3:0] dq_drive = 4'b0000;

	assign qspi_dq_in = dq_drive;

	// Array content, a fixed function of the address
	function automatic logic [7:0] flash_byte(input logic [23:0] a);
		return (a[23:16] ^ a[15:8] ^ a[7:0]) + 8'h5A;
	endfunction

	always @(posedge qspi_sck or negedge qspi_sck or posedge qspi_cs_n) begin
		if (qspi_cs_n) begin
			// Deselected, back to waiting for a command
			bit_cnt = 0;
			driving = 1'b0;
			low_nibble = 1'b0;
			dq_drive = 4'b0000;
		end else if (qspi_sck) begin
			if (driving) begin
				// Host has to release all four pins while the flash drives
				if (qspi_dq_tris != 4'b1111) begin
					protocol_errors++;
					$display("Flash model: host drives dq pins %b in the data phase", ~qspi_dq_tris);
				end
			end else if (bit_cnt < 40) begin
				// Dummy clocks only count
				if (bit_cnt < 32) begin
					hdr_shreg = {hdr_shreg[30:0], qspi_dq_out[0]};
				end
				bit_cnt++;
				if (bit_cnt == 8 && hdr_shreg[7:0] != 8'h6B) begin
					protocol_errors++;
					$display("Flash model: command %h is not a quad output read", hdr_shreg[7:0]);
				end
				if (bit_cnt == 32) begin
					last_cmd = hdr_shreg[31:24];
					last_addr = hdr_shreg[23:0];
					rd_addr = hdr_shreg[23:0];
					header_count++;
				end
			end
		end else if (driving) begin
			// Low nibble next, or move on to the following byte
			if (low_nibble) begin
				rd_addr = rd_addr + 24'd1;
				cur_byte = flash_byte(rd_addr);
				dq_drive = cur_byte[7:4];
			end else begin
				cur_byte = flash_byte(rd_addr);
				dq_drive = cur_byte[3:0];
			end
			low_nibble = !low_nibble;
		end else if (bit_cnt == 40) begin
			// Last dummy falling edge, first high nibble goes out
			driving = 1'b1;
			low_nibble = 1'b0;
			cur_byte = flash_byte(rd_addr);
			dq_drive = cur_byte[7:4];
		end
	end

endmodule

/* testbench/tb_qspi_flash_reader.sv */
`include "qspi_cfg.svh"

module tb_qspi_flash_reader;
	import qspi_pkg::*;

	// Request groups in the order they run
	localparam int NUM_SINGLE = 6;
	localparam int NUM_BURST = 8;
	localparam int NUM_STALL = 8;
	localparam int NUM_DIV = 6;
	localparam int NUM_REQ = NUM_SINGLE + NUM_BURST + NUM_STALL + NUM_DIV;

	logic clk = 1'b0;
	logic reset;
	clk_div_t clkdiv;
	logic req_valid;
	logic req_ready;
	flash_addr_t req_addr;
	xfer_len_t req_len;
	logic rd_valid;
	logic rd_ready;
	qspi_byte_t rd_data;
	logic rd_last;
	logic qspi_sck;
	logic qspi_cs_n;
	logic [3:0] qspi_dq_out;
	logic [3:0] qspi_dq_tris;
	logic [3:0] qspi_dq_in;

	// What the flash model decoded
	logic [7:0] last_cmd;
	logic [23:0] last_addr;
	int header_count;
	int protocol_errors;

	// Request list drawn up front so the cycle limit is known
	flash_addr_t addr_list [NUM_REQ];
	xfer_len_t len_list [NUM_REQ];
	clk_div_t div_list [NUM_REQ];
	logic stall_list [NUM_REQ];

	// Expected read stream
	qspi_byte_t exp_q [$];
	logic exp_last_q [$];

	string test_name = "reset";
	int errors;
	int checks;
	int rx_count;
	longint cycles;
	longint cycle_limit;

	// SCK phase lengths at the pins
	logic sck_prev;
	int phase_len;
	logic seen_high;
	logic low_check = 1'b0;
	int sck_half;

	qspi_flash_reader dut (.*);
	qspi_flash_model flash (.*);

	always #10 clk = ~clk;

	assign sck_half = int'(clkdiv) / 2 + 1;

	task automatic check_value(input string label, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("ERR %s %s expected %0h actual %0h", test_name, label, expected, actual);
		end
	endtask

	// Byte stored at address a
	function automatic qspi_byte_t pattern_byte(input flash_addr_t a);
		return (a[23:16] ^ a[15:8] ^ a[7:0]) + 8'h5A;
	endfunction

	function automatic string group_name(input int n);
		if (n < NUM_SINGLE) begin
			return "single";
		end else if (n < NUM_SINGLE + NUM_BURST) begin
			return "burst";
		end else if (n < NUM_REQ - NUM_DIV) begin
			return "stall";
		end
		return "clkdiv";
	endfunction

	task automatic run_request(input int n);
		int base;
		int hdr_base;
		int k;
		base = rx_count;
		hdr_base = header_count;
		// Low phases are exact only while the read stream never stalls
		low_check = !stall_list[n];
		for (k = 0; k < int'(len_list[n]); k++) begin
			exp_q.push_back(pattern_byte(addr_list[n] + flash_addr_t'(k)));
			exp_last_q.push_back(k == int'(len_list[n]) - 1);
		end
		clkdiv <= div_list[n];
		req_addr <= addr_list[n];
		req_len <= len_list[n];
		req_valid <= 1'b1;
		do begin
			@(posedge clk);
		end while (!req_ready);
		req_valid <= 1'b0;
		// Stall group takes a byte about one cycle in eight
		// so finished bytes wait in the transceiver and SCK pauses
		do begin
			@(posedge clk);
			rd_ready <= stall_list[n] ? ($urandom_range(7, 0) == 0) : 1'b1;
		end while (!(req_ready && exp_q.size() == 0));
		rd_ready <= 1'b1;
		check_value("byte count", 32'(len_list[n]), 32'(rx_count - base));
		check_value("cs_n idle", 32'd1, 32'(qspi_cs_n));
		check_value("command", 32'(`QSPI_CMD_QREAD), 32'(last_cmd));
		check_value("address", 32'(addr_list[n]), 32'(last_addr));
		check_value("headers", 32'(hdr_base + 1), 32'(header_count));
	endtask

	// Read stream and SCK phase checks
	always @(posedge clk) begin
		if (reset) begin
			sck_prev <= 1'b0;
			phase_len <= 0;
			seen_high <= 1'b0;
		end else begin
			if (rd_valid && rd_ready) begin
				rx_count <= rx_count + 1;
				if (exp_q.size() == 0) begin
					errors++;
					$display("Read byte %h arrived with no byte expected", rd_data);
				end else begin
					check_value("rd_data", 32'(exp_q.pop_front()), 32'(rd_data));
					check_value("rd_last", 32'(exp_last_q.pop_front()), 32'(rd_last));
				end
			end
			if (qspi_sck == sck_prev) begin
				phase_len <= phase_len + 1;
			end else begin
				// First low phase of a request also holds the start up delay
				if (sck_prev) begin
					check_value("sck high", sck_half, phase_len);
				end else if (seen_high && low_check) begin
					check_value("sck low", sck_half, phase_len);
				end
				phase_len <= 1;
			end
			if (qspi_cs_n) begin
				seen_high <= 1'b0;
			end else if (sck_prev && !qspi_sck) begin
				seen_high <= 1'b1;
			end
			sck_prev <= qspi_sck;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles with %0d errors so far", cycles, errors);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		int n;
		void'($urandom(64));
		reset <= 1'b1;
		clkdiv <= clk_div_t'(2);
		req_valid <= 1'b0;
		req_addr <= '0;
		req_len <= '0;
		rd_ready <= 1'b1;
		cycle_limit = 50;
		for (n = 0; n < NUM_REQ; n++) begin
			addr_list[n] = flash_addr_t'($urandom);
			len_list[n] = (n < NUM_SINGLE) ? xfer_len_t'(1) :
				xfer_len_t'($urandom_range(16, 2));
			div_list[n] = (n < NUM_REQ - NUM_DIV) ? clk_div_t'(2) :
				clk_div_t'(2 * $urandom_range(5, 1));
			stall_list[n] = (n >= NUM_SINGLE + NUM_BURST) && (n < NUM_REQ - NUM_DIV);
			// Header plus data bytes at 8 SCK periods each
			cycle_limit += (longint'(len_list[n]) + 5) * 16 *
				(longint'(div_list[n]) / 2 + 1) + 100;
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		check_value("req_ready", 32'd1, 32'(req_ready));
		check_value("rd_valid", 32'd0, 32'(rd_valid));
		check_value("cs_n", 32'd1, 32'(qspi_cs_n));
		check_value("sck", 32'd0, 32'(qspi_sck));
		check_value("dq_tris", 32'he, 32'(qspi_dq_tris));
		check_value("dq_out", 32'd0, 32'(qspi_dq_out));
		for (n = 0; n < NUM_REQ; n++) begin
			test_name = group_name(n);
			run_request(n);
		end
		test_name = "summary";
		check_value("protocol errors", 32'd0, 32'(protocol_errors));
		$display("Checks %0d, errors %0d, flash protocol errors %0d", checks, errors,
			protocol_errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
